//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  strb_t;
  typedef logic [2:0]  funct3_t;

  // Major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_RTYPE  = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } res_src_e;

endpackage

`default_nettype wire

//--- hdl/rv_fetch.sv
`default_nettype none
`timescale 1ns/10ps

module rv_fetch
  import rv_pkg::*;
#(
  parameter xlen_t RESET_PC = '0
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  redirect,
  input  xlen_t redirect_target,
  input  logic  halt_req,
  input  logic  halt_is_trap,
  input  logic  imem_rvalid,
  output logic  imem_arvalid,
  output xlen_t pc,
  output logic  instr_valid,
  output logic  ebreak,
  output logic  trap
);

  // High from the second cycle after reset until a halt
  logic running;

  assign imem_arvalid = running;
  assign instr_valid  = running && imem_rvalid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= RESET_PC;
      running <= 1'b0;
      ebreak  <= 1'b0;
      trap    <= 1'b0;
    end else if (halt_req) begin
      // Stop fetching, flags stay set until reset
      running <= 1'b0;
      ebreak  <= !halt_is_trap;
      trap    <= halt_is_trap;
    end else if (instr_valid) begin
      pc <= redirect ? redirect_target : pc + 32'd4;
    end else if (!ebreak && !trap) begin
      // Start after reset, PC held while stalled
      running <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rv_decode.sv
`default_nettype none
`timescale 1ns/10ps

module rv_decode
  import rv_pkg::*;
(
  input  instr_t    instr,
  input  logic      instr_valid,
  input  xlen_t     pc,
  input  xlen_t     alu_result,
  input  xlen_t     load_data,
  input  logic      misaligned,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output reg_addr_t rd,
  output xlen_t     imm,
  output alu_op_e   alu_op,
  output logic      alu_a_pc,
  output logic      alu_b_imm,
  output logic      is_branch,
  output logic      is_jal,
  output logic      is_jalr,
  output funct3_t   funct3,
  output logic      mem_read,
  output logic      mem_write,
  output logic      reg_write,
  output xlen_t     rd_data,
  output logic      halt_req,
  output logic      halt_is_trap
);

  localparam instr_t EBREAK_INSTR = 32'h0010_0073;

  opcode_e    opcode;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  res_src_e   res_src;
  logic       is_load;
  logic       is_store;
  logic       writes_rd;
  logic       is_ebreak;
  logic       illegal;
  logic       trap_cond;

  // Shared by OP and OP-IMM, alt selects SUB or SRA
  function automatic alu_op_e alu_op_of(input funct3_t f3, input logic alt);
    case (f3)
      3'd0:    return alt ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return alt ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // ------------------------------------------------------------
  // Fields and immediates
  // ------------------------------------------------------------
  assign opcode = opcode_e'(instr[6:0]);
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ------------------------------------------------------------
  // Control decode
  // ------------------------------------------------------------
  always_comb begin
    imm       = imm_i;
    alu_op    = ALU_ADD;
    alu_a_pc  = 1'b0;
    alu_b_imm = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    writes_rd = 1'b0;
    res_src   = RES_ALU;
    is_ebreak = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      OP_LUI: begin
        imm       = imm_u;
        alu_op    = ALU_PASS_B;
        alu_b_imm = 1'b1;
        writes_rd = 1'b1;
      end
      OP_AUIPC: begin
        imm       = imm_u;
        alu_a_pc  = 1'b1;
        alu_b_imm = 1'b1;
        writes_rd = 1'b1;
      end
      OP_JAL: begin
        imm       = imm_j;
        is_jal    = 1'b1;
        writes_rd = 1'b1;
        res_src   = RES_PC4;
      end
      OP_JALR: begin
        is_jalr   = 1'b1;
        writes_rd = 1'b1;
        res_src   = RES_PC4;
        illegal   = funct3 != 3'd0;
      end
      OP_BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
        illegal   = funct3[2:1] == 2'b01;
      end
      OP_LOAD: begin
        alu_b_imm = 1'b1;
        is_load   = 1'b1;
        writes_rd = 1'b1;
        res_src   = RES_MEM;
        illegal   = funct3 == 3'd3 || funct3[2:1] == 2'b11;
      end
      OP_STORE: begin
        imm       = imm_s;
        alu_b_imm = 1'b1;
        is_store  = 1'b1;
        illegal   = funct3[2] || funct3 == 3'd3;
      end
      OP_IMM: begin
        alu_b_imm = 1'b1;
        writes_rd = 1'b1;
        alu_op    = alu_op_of(funct3, funct3 == 3'd5 && funct7[5]);
        illegal   = (funct3 == 3'd1 && funct7 != 7'd0) ||
                    (funct3 == 3'd5 && (funct7 & 7'b1011111) != 7'd0);
      end
      OP_RTYPE: begin
        writes_rd = 1'b1;
        alu_op    = alu_op_of(funct3, funct7[5]);
        illegal   = (funct7 & 7'b1011111) != 7'd0 ||
                    (funct7[5] && funct3 != 3'd0 && funct3 != 3'd5);
      end
      OP_SYSTEM: begin
        // EBREAK halts and every other SYSTEM op traps
        is_ebreak = instr == EBREAK_INSTR;
        illegal   = instr != EBREAK_INSTR;
      end
      default: illegal = 1'b1;
    endcase
  end

  // ------------------------------------------------------------
  // Halt and side-effect gating
  // ------------------------------------------------------------
  assign trap_cond    = illegal || misaligned;
  assign halt_req     = instr_valid && (is_ebreak || trap_cond);
  assign halt_is_trap = trap_cond;

  // Misaligned accesses are held back inside the lsu
  assign mem_read  = instr_valid && is_load && !illegal;
  assign mem_write = instr_valid && is_store && !illegal;
  assign reg_write = instr_valid && writes_rd && !trap_cond;

  // Write-back select
  always_comb begin
    case (res_src)
      RES_MEM: rd_data = load_data;
      RES_PC4: rd_data = pc + 32'd4;
      default: rd_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/rv_regfile.sv
`default_nettype none
`timescale 1ns/10ps

module rv_regfile
  import rv_pkg::*;
(
  input  logic      clk,
  input  reg_addr_t rs1,
  input  reg_addr_t rs2,
  input  reg_addr_t rd,
  input  logic      reg_write,
  input  xlen_t     rd_data,
  output xlen_t     rs1_data,
  output xlen_t     rs2_data
);

  // x0 has no storage
  xlen_t regs [1:31];

  always_ff @(posedge clk) begin
    if (reg_write && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- hdl/rv_execute.sv
`default_nettype none
`timescale 1ns/10ps

module rv_execute
  import rv_pkg::*;
(
  input  xlen_t   pc,
  input  xlen_t   imm,
  input  xlen_t   rs1_data,
  input  xlen_t   rs2_data,
  input  alu_op_e alu_op,
  input  logic    alu_a_pc,
  input  logic    alu_b_imm,
  input  logic    is_branch,
  input  logic    is_jal,
  input  logic    is_jalr,
  input  funct3_t funct3,
  output xlen_t   alu_result,
  output logic    redirect,
  output xlen_t   redirect_target
);

  xlen_t      op_a;
  xlen_t      op_b;
  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;
  logic       taken;
  xlen_t      jalr_sum;

  // ------------------------------------------------------------
  // ALU
  // ------------------------------------------------------------
  assign op_a  = alu_a_pc ? pc : rs1_data;
  assign op_b  = alu_b_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  alu_result = op_a + op_b;
      ALU_SUB:  alu_result = op_a - op_b;
      ALU_SLL:  alu_result = op_a << shamt;
      ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      ALU_XOR:  alu_result = op_a ^ op_b;
      ALU_SRL:  alu_result = op_a >> shamt;
      ALU_SRA:  alu_result = xlen_t'($signed(op_a) >>> shamt);
      ALU_OR:   alu_result = op_a | op_b;
      ALU_AND:  alu_result = op_a & op_b;
      default:  alu_result = op_b;
    endcase
  end

  // ------------------------------------------------------------
  // Branch compare and jump target
  // ------------------------------------------------------------
  assign eq  = rs1_data == rs2_data;
  assign lt  = $signed(rs1_data) < $signed(rs2_data);
  assign ltu = rs1_data < rs2_data;

  always_comb begin
    case (funct3)
      3'b000:  taken = eq;
      3'b001:  taken = !eq;
      3'b100:  taken = lt;
      3'b101:  taken = !lt;
      3'b110:  taken = ltu;
      3'b111:  taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum        = rs1_data + imm;
  assign redirect        = is_jal || is_jalr || (is_branch && taken);
  assign redirect_target = is_jalr ? {jalr_sum[31:1], 1'b0} : pc + imm;

endmodule

`default_nettype wire

//--- hdl/rv_lsu.sv
`default_nettype none
`timescale 1ns/10ps

module rv_lsu
  import rv_pkg::*;
(
  input  logic    instr_valid,
  input  logic    mem_read,
  input  logic    mem_write,
  input  funct3_t funct3,
  input  xlen_t   addr,
  input  xlen_t   store_data,
  input  xlen_t   dmem_rdata,
  output logic    dmem_ren,
  output logic    dmem_we,
  output xlen_t   dmem_raddr,
  output xlen_t   dmem_waddr,
  output xlen_t   dmem_wdata,
  output strb_t   dmem_wstrb,
  output xlen_t   load_data,
  output logic    misaligned
);

  logic [1:0] size;
  logic [1:0] offset;
  logic       bad_align;
  xlen_t      word_addr;
  xlen_t      shifted;

  assign size      = funct3[1:0];
  assign offset    = addr[1:0];
  assign word_addr = {addr[31:2], 2'b00};

  // Halfword on odd byte, word off a 4-byte boundary
  assign bad_align  = (size == 2'd1 && offset[0]) || (size == 2'd2 && offset != 2'd0);
  assign misaligned = instr_valid && (mem_read || mem_write) && bad_align;

  assign dmem_ren   = instr_valid && mem_read && !bad_align;
  assign dmem_we    = instr_valid && mem_write && !bad_align;
  assign dmem_raddr = word_addr;
  assign dmem_waddr = word_addr;

  // Store data is replicated, the strobe picks the lane
  always_comb begin
    case (size)
      2'd0: begin
        dmem_wdata = {4{store_data[7:0]}};
        dmem_wstrb = strb_t'(4'b0001 << offset);
      end
      2'd1: begin
        dmem_wdata = {2{store_data[15:0]}};
        dmem_wstrb = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata = store_data;
        dmem_wstrb = 4'b1111;
      end
    endcase
  end

  // Loaded lane moved down to bit 0, then extended
  assign shifted = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (funct3)
      3'b000:  load_data = {{24{shifted[7]}}, shifted[7:0]};
      3'b001:  load_data = {{16{shifted[15]}}, shifted[15:0]};
      3'b100:  load_data = {24'b0, shifted[7:0]};
      3'b101:  load_data = {16'b0, shifted[15:0]};
      default: load_data = shifted;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`default_nettype none
`timescale 1ns/10ps

module rv_core
  import rv_pkg::*;
#(
  parameter xlen_t RESET_PC = '0
) (
  input  logic   clk,
  input  logic   rst_n,

  // Instruction memory
  output logic   imem_arvalid,
  output xlen_t  imem_araddr,
  input  instr_t imem_rdata,
  input  logic   imem_rvalid,

  // Data memory
  output logic   dmem_ren,
  output xlen_t  dmem_raddr,
  input  xlen_t  dmem_rdata,
  output logic   dmem_we,
  output xlen_t  dmem_waddr,
  output xlen_t  dmem_wdata,
  output strb_t  dmem_wstrb,

  output logic   ebreak,
  output logic   trap
);

  xlen_t     pc;
  logic      instr_valid;
  logic      redirect;
  xlen_t     redirect_target;
  logic      halt_req;
  logic      halt_is_trap;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  xlen_t     imm;
  alu_op_e   alu_op;
  logic      alu_a_pc;
  logic      alu_b_imm;
  logic      is_branch;
  logic      is_jal;
  logic      is_jalr;
  funct3_t   funct3;
  logic      mem_read;
  logic      mem_write;
  logic      reg_write;
  xlen_t     rd_data;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     alu_result;
  xlen_t     load_data;
  logic      misaligned;

  assign imem_araddr = pc;

  rv_fetch #(
    .RESET_PC(RESET_PC)
  ) i_rv_fetch (.*);

  rv_decode i_rv_decode (
    .instr(imem_rdata),
    .*
  );

  rv_regfile i_rv_regfile (.*);

  rv_execute i_rv_execute (.*);

  rv_lsu i_rv_lsu (
    .addr      (alu_result),
    .store_data(rs2_data),
    .*
  );

endmodule

`default_nettype wire

//--- tb/tb_mem.sv
`default_nettype none
`timescale 1ns/10ps

module tb_mem
  import rv_pkg::*;
#(
  parameter int PROGRAM = 0
) (
  input  logic   clk,
  input  xlen_t  imem_araddr,
  output instr_t imem_rdata,
  input  xlen_t  dmem_raddr,
  output xlen_t  dmem_rdata,
  input  logic   dmem_we,
  input  xlen_t  dmem_waddr,
  input  xlen_t  dmem_wdata,
  input  strb_t  dmem_wstrb
);

  localparam instr_t EBREAK_WORD = 32'h0010_0073;

  instr_t rom [0:127];
  xlen_t  ram [0:511];

  // ------------------------------------------------------------
  // Instruction encoders
  // ------------------------------------------------------------
  function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input funct3_t f3,
                                   input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OP_RTYPE};
  endfunction

  function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                   input funct3_t f3, input reg_addr_t rd,
                                   input opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instr_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic instr_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic instr_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                   input opcode_e op);
    return {imm, rd, op};
  endfunction

  function automatic instr_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  // ADDI-style op on rd, and SW relative to the x10 base
  function automatic instr_t alu_imm(input logic [11:0] imm, input reg_addr_t rs1,
                                     input funct3_t f3, input reg_addr_t rd);
    return enc_i(imm, rs1, f3, rd, OP_IMM);
  endfunction

  function automatic instr_t store_word(input logic [11:0] off, input reg_addr_t rs2);
    return enc_s(off, rs2, 5'd10, 3'b010);
  endfunction

  // ------------------------------------------------------------
  // Program images
  // ------------------------------------------------------------
  initial begin
    for (int i = 0; i < 128; i++) begin
      rom[i] = '0;
    end
    for (int i = 0; i < 512; i++) begin
      ram[i] = (xlen_t'(i * 4) * 32'h9E37_79B9) ^ 32'h5A5A_0000;
    end
    if (PROGRAM == 0) begin
      rom[0]  = alu_imm(12'd5, 5'd0, 3'b000, 5'd1);
      rom[1]  = alu_imm(12'hFFD, 5'd0, 3'b000, 5'd2);
      rom[2]  = alu_imm(12'h400, 5'd0, 3'b000, 5'd10);
      rom[3]  = enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);
      rom[4]  = store_word(12'd0, 5'd3);
      rom[5]  = enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3);
      rom[6]  = store_word(12'd4, 5'd3);
      rom[7]  = enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd3);
      rom[8]  = store_word(12'd8, 5'd3);
      rom[9]  = enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd3);
      rom[10] = store_word(12'd12, 5'd3);
      rom[11] = enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3);
      rom[12] = store_word(12'd16, 5'd3);
      rom[13] = enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3);
      rom[14] = store_word(12'd20, 5'd3);
      rom[15] = enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3);
      rom[16] = store_word(12'd24, 5'd3);
      rom[17] = alu_imm(12'd4, 5'd1, 3'b001, 5'd3);
      rom[18] = store_word(12'd28, 5'd3);
      rom[19] = alu_imm(12'h401, 5'd2, 3'b101, 5'd3);
      rom[20] = store_word(12'd32, 5'd3);
      rom[21] = alu_imm(12'd28, 5'd2, 3'b101, 5'd3);
      rom[22] = store_word(12'd36, 5'd3);
      rom[23] = enc_u(20'h12345, 5'd3, OP_LUI);
      rom[24] = store_word(12'd40, 5'd3);
      rom[25] = enc_u(20'h00001, 5'd3, OP_AUIPC);
      rom[26] = store_word(12'd44, 5'd3);
      // Countdown loop, three passes
      rom[27] = alu_imm(12'd3, 5'd0, 3'b000, 5'd4);
      rom[28] = alu_imm(12'd0, 5'd0, 3'b000, 5'd5);
      rom[29] = alu_imm(12'd1, 5'd5, 3'b000, 5'd5);
      rom[30] = alu_imm(12'hFFF, 5'd4, 3'b000, 5'd4);
      rom[31] = enc_b(13'h1FF8, 5'd0, 5'd4, 3'b001);
      rom[32] = store_word(12'd48, 5'd5);
      rom[33] = enc_b(13'd8, 5'd2, 5'd1, 3'b000);
      rom[34] = store_word(12'd52, 5'd1);
      rom[35] = enc_b(13'd12, 5'd1, 5'd2, 3'b100);
      rom[36] = store_word(12'd56, 5'd2);
      rom[37] = store_word(12'd56, 5'd2);
      rom[38] = enc_b(13'd8, 5'd1, 5'd2, 3'b110);
      rom[39] = store_word(12'd56, 5'd1);
      // Call, return and jump over the subroutine
      rom[40] = enc_j(21'd16, 5'd6);
      rom[41] = store_word(12'd60, 5'd6);
      rom[42] = enc_j(21'd24, 5'd0);
      rom[43] = store_word(12'd68, 5'd2);
      rom[44] = alu_imm(12'h077, 5'd0, 3'b000, 5'd7);
      rom[45] = store_word(12'd64, 5'd7);
      rom[46] = enc_i(12'd0, 5'd6, 3'b000, 5'd0, OP_JALR);
      rom[47] = store_word(12'd68, 5'd2);
      // Memory widths on 0x80F17F82
      rom[48] = enc_u(20'h80F18, 5'd8, OP_LUI);
      rom[49] = alu_imm(12'hF82, 5'd8, 3'b000, 5'd8);
      rom[50] = store_word(12'd72, 5'd8);
      rom[51] = enc_i(12'd72, 5'd10, 3'b000, 5'd9, OP_LOAD);
      rom[52] = store_word(12'd76, 5'd9);
      rom[53] = enc_i(12'd72, 5'd10, 3'b100, 5'd9, OP_LOAD);
      rom[54] = store_word(12'd80, 5'd9);
      rom[55] = enc_i(12'd74, 5'd10, 3'b001, 5'd9, OP_LOAD);
      rom[56] = store_word(12'd84, 5'd9);
      rom[57] = enc_i(12'd74, 5'd10, 3'b101, 5'd9, OP_LOAD);
      rom[58] = store_word(12'd88, 5'd9);
      rom[59] = enc_s(12'd92, 5'd8, 5'd10, 3'b000);
      rom[60] = enc_s(12'd93, 5'd8, 5'd10, 3'b000);
      rom[61] = enc_s(12'd94, 5'd8, 5'd10, 3'b000);
      rom[62] = enc_s(12'd95, 5'd8, 5'd10, 3'b000);
      rom[63] = enc_s(12'd96, 5'd8, 5'd10, 3'b001);
      rom[64] = enc_s(12'd98, 5'd8, 5'd10, 3'b001);
      rom[65] = alu_imm(12'd123, 5'd0, 3'b000, 5'd0);
      rom[66] = store_word(12'd100, 5'd0);
      rom[67] = EBREAK_WORD;
      rom[68] = store_word(12'd104, 5'd1);
    end else begin
      // Misaligned LW, then a store and an unknown opcode
      rom[0] = alu_imm(12'h400, 5'd0, 3'b000, 5'd10);
      rom[1] = enc_i(12'd2, 5'd10, 3'b010, 5'd3, OP_LOAD);
      rom[2] = store_word(12'd0, 5'd10);
      rom[3] = 32'h0000_007F;
    end
  end

  assign imem_rdata = rom[imem_araddr[8:2]];
  assign dmem_rdata = ram[dmem_raddr[10:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wstrb[b]) begin
          ram[dmem_waddr[10:2]][b*8 +: 8] <= dmem_wdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_rv_core.sv
`default_nettype none
`timescale 1ns/10ps

module tb_rv_core
  import rv_pkg::*;
;

  localparam xlen_t RESET_PC   = 32'h0000_0000;
  localparam int    NUM_STORES = 29;
  localparam int    NUM_LOADS  = 4;
  localparam xlen_t LOAD_ADDR  = 32'h0000_0448;
  localparam int    MAX_CYCLES = 5000;

  logic   clk;
  logic   rst_n;
  logic   imem_arvalid;
  xlen_t  imem_araddr;
  instr_t imem_rdata;
  logic   imem_rvalid;
  logic   dmem_ren;
  xlen_t  dmem_raddr;
  xlen_t  dmem_rdata;
  logic   dmem_we;
  xlen_t  dmem_waddr;
  xlen_t  dmem_wdata;
  strb_t  dmem_wstrb;
  logic   ebreak;
  logic   trap;

  instr_t rom0_rdata;
  instr_t rom1_rdata;
  xlen_t  ram0_rdata;
  xlen_t  ram1_rdata;
  logic   image_sel;
  logic   stall_mode;

  xlen_t  exp_addr [0:NUM_STORES-1];
  strb_t  exp_strb [0:NUM_STORES-1];
  xlen_t  exp_data [0:NUM_STORES-1];
  int     exp_idx;
  int     exp_limit;
  int     n_tables;
  int     load_count;

  rv_core #(
    .RESET_PC(RESET_PC)
  ) i_rv_core (.*);

  tb_mem #(.PROGRAM(0)) i_mem_main (
    .clk(clk), .imem_araddr(imem_araddr), .imem_rdata(rom0_rdata),
    .dmem_raddr(dmem_raddr), .dmem_rdata(ram0_rdata), .dmem_we(dmem_we),
    .dmem_waddr(dmem_waddr), .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb)
  );

  tb_mem #(.PROGRAM(1)) i_mem_trap (
    .clk(clk), .imem_araddr(imem_araddr), .imem_rdata(rom1_rdata),
    .dmem_raddr(dmem_raddr), .dmem_rdata(ram1_rdata), .dmem_we(dmem_we),
    .dmem_waddr(dmem_waddr), .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb)
  );

  assign imem_rdata = image_sel ? rom1_rdata : rom0_rdata;
  assign dmem_rdata = image_sel ? ram1_rdata : ram0_rdata;

  always #20 clk = ~clk;

  // ------------------------------------------------------------
  // Failure reporting and helpers
  // ------------------------------------------------------------
  task automatic report_mismatch(input string what);
    $display("mismatch at %0t ns: %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "check failed");
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "run aborted");
  endtask

  function automatic xlen_t lane_mask(input strb_t s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  task automatic add_store(input xlen_t a, input strb_t s, input xlen_t d);
    exp_addr[n_tables] = a;
    exp_strb[n_tables] = s;
    exp_data[n_tables] = d;
    n_tables++;
  endtask

  task automatic drive_rvalid();
    imem_rvalid = stall_mode ? ($urandom % 4 != 0) : 1'b1;
  endtask

  // Every store is checked against the next table entry, every load
  // against the one word the program reads
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_idx    = 0;
      load_count = 0;
    end else begin
      if (dmem_we) begin
        assert (imem_rvalid) else report_mismatch("store while imem_rvalid low");
        assert (exp_idx < exp_limit) else report_mismatch("unexpected store");
        assert (dmem_waddr == exp_addr[exp_idx])
          else report_mismatch($sformatf("waddr %h, expected %h",
                                          dmem_waddr, exp_addr[exp_idx]));
        assert (dmem_wstrb == exp_strb[exp_idx])
          else report_mismatch($sformatf("wstrb %b, expected %b",
                                          dmem_wstrb, exp_strb[exp_idx]));
        assert ((dmem_wdata & lane_mask(dmem_wstrb)) == exp_data[exp_idx])
          else report_mismatch($sformatf("wdata %h, expected %h",
                                          dmem_wdata, exp_data[exp_idx]));
        exp_idx = exp_idx + 1;
      end
      if (dmem_ren) begin
        assert (imem_rvalid) else report_mismatch("load while imem_rvalid low");
        assert (dmem_raddr == LOAD_ADDR)
          else report_mismatch($sformatf("raddr %h, expected %h",
                                          dmem_raddr, LOAD_ADDR));
        load_count = load_count + 1;
      end
    end
  end

  // ------------------------------------------------------------
  // One run from reset to halt
  // ------------------------------------------------------------
  task automatic run_program(input logic sel, input logic stalls, input logic want_trap);
    int cycles;
    image_sel   = sel;
    stall_mode  = stalls;
    exp_limit   = sel ? 0 : NUM_STORES;
    rst_n       = 1'b0;
    imem_rvalid = 1'b1;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    assert (!imem_arvalid && !dmem_we && !dmem_ren && !ebreak && !trap)
      else report_mismatch("outputs active in first cycle after reset");
    assert (imem_araddr == RESET_PC) else report_mismatch("imem_araddr not RESET_PC");
    cycles = 0;
    while (!ebreak && !trap) begin
      @(negedge clk);
      drive_rvalid();
      cycles++;
      if (cycles > MAX_CYCLES) begin
        report_failure("Timeout: the core never halted");
      end
    end
    assert (trap == want_trap && ebreak == !want_trap)
      else report_mismatch($sformatf("halt flags ebreak=%b trap=%b", ebreak, trap));
    assert (exp_idx == exp_limit)
      else report_mismatch($sformatf("%0d of %0d stores seen", exp_idx, exp_limit));
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      drive_rvalid();
      assert (!imem_arvalid) else report_mismatch("imem_arvalid high after halt");
      assert (trap == want_trap && ebreak == !want_trap)
        else report_mismatch("halt flag not sticky");
    end
    // The misaligned load of the trap image is never issued
    assert (load_count == (sel ? 0 : NUM_LOADS))
      else report_mismatch($sformatf("%0d loads issued, expected %0d",
                                      load_count, sel ? 0 : NUM_LOADS));
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    imem_rvalid = 1'b0;
    image_sel   = 1'b0;
    stall_mode  = 1'b0;
    exp_limit   = 0;
    n_tables    = 0;
    void'($urandom(95603));

    add_store(32'h400, 4'hF, 32'h0000_0002);
    add_store(32'h404, 4'hF, 32'h0000_0008);
    add_store(32'h408, 4'hF, 32'h0000_0001);
    add_store(32'h40C, 4'hF, 32'h0000_0000);
    add_store(32'h410, 4'hF, 32'hFFFF_FFF8);
    add_store(32'h414, 4'hF, 32'hFFFF_FFFD);
    add_store(32'h418, 4'hF, 32'h0000_0005);
    add_store(32'h41C, 4'hF, 32'h0000_0050);
    add_store(32'h420, 4'hF, 32'hFFFF_FFFE);
    add_store(32'h424, 4'hF, 32'h0000_000F);
    add_store(32'h428, 4'hF, 32'h1234_5000);
    add_store(32'h42C, 4'hF, 32'h0000_1064);
    add_store(32'h430, 4'hF, 32'h0000_0003);
    add_store(32'h434, 4'hF, 32'h0000_0005);
    add_store(32'h438, 4'hF, 32'h0000_0005);
    add_store(32'h440, 4'hF, 32'h0000_0077);
    add_store(32'h43C, 4'hF, 32'h0000_00A4);
    add_store(32'h448, 4'hF, 32'h80F1_7F82);
    add_store(32'h44C, 4'hF, 32'hFFFF_FF82);
    add_store(32'h450, 4'hF, 32'h0000_0082);
    add_store(32'h454, 4'hF, 32'hFFFF_80F1);
    add_store(32'h458, 4'hF, 32'h0000_80F1);
    add_store(32'h45C, 4'h1, 32'h0000_0082);
    add_store(32'h45C, 4'h2, 32'h0000_8200);
    add_store(32'h45C, 4'h4, 32'h0082_0000);
    add_store(32'h45C, 4'h8, 32'h8200_0000);
    add_store(32'h460, 4'h3, 32'h0000_7F82);
    add_store(32'h460, 4'hC, 32'h7F82_0000);
    add_store(32'h464, 4'hF, 32'h0000_0000);

    @(negedge clk);
    run_program(1'b0, 1'b0, 1'b0);
    run_program(1'b0, 1'b1, 1'b0);
    run_program(1'b1, 1'b1, 1'b1);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hdl/rv_pkg.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_execute.sv
hdl/rv_lsu.sv
hdl/rv_core.sv
tb/tb_mem.sv
tb/tb_rv_core.sv

//--- run.sh
#!/bin/sh
# Build and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f files.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_rv_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^NO ERRORS$"; then
  exit 0
fi
exit 1
